// ==== verif/cpu_memory_system_golden.txt ====
# test name, op (W or R), address, write data, expected read byte
# numbers are hex and unused columns hold 00
reset_read      R 0000 00 00
write_readback  W 0005 a5 00
write_readback  W 0042 3c 00
write_readback  W 0123 e7 00
write_readback  W 03ff 81 00
write_readback  R 0005 00 a5
write_readback  R 0042 00 3c
write_readback  R 0123 00 e7
write_readback  R 03ff 00 81
byte_lanes      W 0080 11 00
byte_lanes      W 0081 22 00
byte_lanes      W 0082 33 00
byte_lanes      W 0083 44 00
byte_lanes      R 0080 00 11
byte_lanes      R 0081 00 22
byte_lanes      R 0082 00 33
byte_lanes      R 0083 00 44
bank_separation W 0010 0a 00
bank_separation W 0110 1b 00
bank_separation W 0210 2c 00
bank_separation W 0310 3d 00
bank_separation R 0010 00 0a
bank_separation R 0110 00 1b
bank_separation R 0210 00 2c
bank_separation R 0310 00 3d
unmapped        R 0400 00 ff
unmapped        R fffc 00 ff
unmapped        W 0410 99 00
unmapped        R 0010 00 0a
unmapped        R 0411 00 ff

// ==== compile.f ====
common/cpu_bus_pkg.sv
hdl/cpu_bus_bridge.sv
hdl/sram_bank.sv
hdl/apb_response_mux.sv
hdl/cpu_memory_system.sv
verif/cpu_memory_system_assert.sv
verif/cpu_memory_system_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_memory_system

sources:
  - files:
      - common/cpu_bus_pkg.sv
      - hdl/cpu_bus_bridge.sv
      - hdl/sram_bank.sv
      - hdl/apb_response_mux.sv
      - hdl/cpu_memory_system.sv
  - target: test
    files:
      - verif/cpu_memory_system_assert.sv
      - verif/cpu_memory_system_tb.sv

// ==== verif/cpu_memory_system_tb.sv ====
`timescale 1ns/100ps

module cpu_memory_system_tb;

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 16;
    localparam int          RANDOM_OPS   = 200;
    localparam int          MAX_GOLDEN   = 64;
    localparam int          ACCESS_LIMIT = 16;   // cycles before an access counts as lost
    localparam logic [15:0] RAM_TOP      = 16'h0400;
    localparam string       GOLDEN_FILE  = "verif/cpu_memory_system_golden.txt";

    logic        clk = 1'b0;
    logic        rst;
    logic        cpu_valid;
    logic        cpu_rwb;
    logic        cpu_sync;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_data_in;
    logic [7:0]  cpu_data_out;
    logic [7:0]  cpu_data_oe;
    logic        cpu_rdy;
    logic        cpu_reset;

    // golden operations loaded before reset
    reg [8*24-1:0] g_name [MAX_GOLDEN];
    logic          g_write [MAX_GOLDEN];
    logic [15:0]   g_addr [MAX_GOLDEN];
    logic [7:0]    g_data [MAX_GOLDEN];
    logic [7:0]    g_exp [MAX_GOLDEN];
    int            n_golden = 0;
    int            ops_total = 0;
    logic          file_error = 1'b0;

    logic [7:0]    ref_mem [1024];  // byte image of the ram
    reg [8*24-1:0] cur_test;
    int            test_ops;
    int            test_errors;
    int            tests_passed = 0;
    int            tests_failed = 0;
    logic [31:0]   rng;
    logic [15:0]   r_addr;
    logic          r_write;
    logic [7:0]    r_data;

    always #(CLK_PERIOD/2) clk = ~clk;

    cpu_memory_system dut (
        .i_sysclk      (clk),
        .i_reset       (rst),
        .i_cpu_valid   (cpu_valid),
        .i_cpu_rwb     (cpu_rwb),
        .i_cpu_sync    (cpu_sync),
        .i_cpu_addr    (cpu_addr),
        .i_cpu_data    (cpu_data_in),
        .o_cpu_data    (cpu_data_out),
        .o_cpu_data_oe (cpu_data_oe),
        .o_cpu_rdy     (cpu_rdy),
        .o_cpu_reset   (cpu_reset)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input [8*24-1:0] name, input [31:0] expected,
                               input [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %0s: expected %0h, actual %0h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic start_test(input [8*24-1:0] name);
        cur_test    = name;
        test_ops    = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        $display("test %0s done: %0d ops, %0d mismatches", cur_test, test_ops, test_errors);
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
    endtask

    task automatic load_golden();
        int            fd;
        int            rc;
        int            n;
        reg [8*80-1:0] text_line;
        reg [8*24-1:0] name;
        reg [7:0]      op;
        logic [15:0]   addr;
        logic [7:0]    data;
        logic [7:0]    exp_byte;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("could not open golden file %0s", GOLDEN_FILE);
            file_error = 1'b1;
            return;
        end
        while (!$feof(fd) && n_golden < MAX_GOLDEN) begin
            text_line = '0;
            rc = $fgets(text_line, fd);
            n = $sscanf(text_line, "%s %s %h %h %h", name, op, addr, data, exp_byte);
            if (rc > 0 && n == 5 && name != "#") begin  // comment and blank lines drop out
                g_name[n_golden]  = name;
                g_write[n_golden] = (op == "W");
                g_addr[n_golden]  = addr;
                g_data[n_golden]  = data;
                g_exp[n_golden]   = exp_byte;
                n_golden++;
            end
        end
        $fclose(fd);
        if (n_golden == 0) begin
            $display("golden file %0s holds no operations", GOLDEN_FILE);
            file_error = 1'b1;
        end
    endtask

    // one cpu cycle with valid then wait for rdy at falling edges
    task automatic cpu_access(input logic rwb, input [15:0] addr, input [7:0] wdata,
                              output [7:0] rdata, output int stall);
        stall = 0;
        @(posedge clk);
        cpu_valid   <= 1'b1;
        cpu_rwb     <= rwb;
        cpu_addr    <= addr;
        cpu_data_in <= wdata;
        @(posedge clk);  // accepting edge
        cpu_valid <= 1'b0;
        @(negedge clk);
        while (!cpu_rdy && stall < ACCESS_LIMIT) begin
            stall++;
            @(negedge clk);
        end
        if (!cpu_rdy) begin
            $display("%0s: access to %h never completed, cpu_rdy stayed low", cur_test, addr);
            test_errors++;
        end
        rdata = cpu_data_out;
    endtask

    task automatic run_op(input logic is_write, input [15:0] addr, input [7:0] wdata,
                          input [7:0] expected);
        logic [7:0] rdata;
        int         stall;
        cpu_access(!is_write, addr, wdata, rdata, stall);
        test_ops++;
        check_value(cur_test, is_write ? 8'h00 : 8'hff, cpu_data_oe);  // pins driven on reads
        if (addr >= RAM_TOP) begin
            check_value(cur_test, 0, stall);  // unmapped never stalls
        end else if (is_write) begin
            ref_mem[addr[9:0]] = wdata;
        end
        if (!is_write) begin
            check_value(cur_test, expected, rdata);
        end
    endtask

    initial begin
        rst         <= 1'b1;
        cpu_valid   <= 1'b0;
        cpu_rwb     <= 1'b1;
        cpu_sync    <= 1'b0;
        cpu_addr    <= '0;
        cpu_data_in <= '0;
        rng = 32'h071d76d3;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = 8'h00;  // banks clear at reset
        end
        load_golden();
        ops_total = n_golden + RANDOM_OPS + 1;

        start_test("reset_signals");
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value(cur_test, 1, cpu_rdy);
        check_value(cur_test, 1, cpu_reset);
        @(negedge clk);
        check_value(cur_test, 0, cpu_reset);
        check_value(cur_test, 1, cpu_rdy);
        finish_test();

        for (int i = 0; i < n_golden; i++) begin
            if (g_name[i] != cur_test) begin
                if (i > 0) begin
                    finish_test();
                end
                start_test(g_name[i]);
            end
            run_op(g_write[i], g_addr[i], g_data[i], g_exp[i]);
        end
        if (n_golden > 0) begin
            finish_test();
        end

        start_test("random_traffic");
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rng     = xorshift32(rng);
            r_addr  = {6'b0, rng[9:0]};
            r_write = rng[16];
            r_data  = rng[31:24];
            run_op(r_write, r_addr, r_data, ref_mem[r_addr[9:0]]);
        end
        finish_test();

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0 && !file_error) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // 20 cycles per operation is far above the 5 an access takes
    initial begin
        wait (ops_total > 0);
        repeat (ops_total * 20 + RESET_CYCLES) @(posedge clk);
        $display("simulation timed out after %0d cycles", ops_total * 20 + RESET_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== verif/cpu_memory_system_assert.sv ====
`timescale 1ns/100ps

module cpu_memory_system_assert (
    input logic                  i_sysclk,
    input logic                  i_reset,
    input cpu_bus_pkg::apb_req_t i_req,
    input cpu_bus_pkg::apb_rsp_t i_rsp,
    input logic                  i_cpu_rdy
);

    logic sel_any;

    assign sel_any = |i_req.psel;

    a_psel_onehot: assert property (@(posedge i_sysclk) disable iff (i_reset)
        $onehot0(i_req.psel))
        else $error("more than one psel bit high");

    // setup phase is exactly one cycle
    a_penable_after_setup: assert property (@(posedge i_sysclk) disable iff (i_reset)
        $rose(i_req.penable) |-> sel_any && $past(sel_any && !i_req.penable)
                                 && !$past(sel_any, 2))
        else $error("penable rose without a one cycle setup phase");

    a_req_stable: assert property (@(posedge i_sysclk) disable iff (i_reset)
        (sel_any && $past(sel_any) && !$past(i_rsp.pready)) |->
            $stable(i_req.psel) && $stable(i_req.pwrite) && $stable(i_req.paddr)
            && $stable(i_req.pwdata) && $stable(i_req.pstrb) && $stable(i_req.bank))
        else $error("request changed during a transfer");

    a_rdy_after_reset: assert property (@(posedge i_sysclk)
        i_reset |=> i_cpu_rdy)
        else $error("cpu_rdy low after reset");

endmodule

bind cpu_bus_bridge cpu_memory_system_assert u_assert (
    .i_sysclk  (i_sysclk),
    .i_reset   (i_reset),
    .i_req     (o_req),
    .i_rsp     (i_rsp),
    .i_cpu_rdy (o_cpu_rdy)
);

// ==== hdl/cpu_memory_system.sv ====
`timescale 1ns/100ps

module cpu_memory_system (
    input  logic                               i_sysclk,
    input  logic                               i_reset,

    input  logic                               i_cpu_valid,
    input  logic                               i_cpu_rwb,
    input  logic                               i_cpu_sync,  // pin kept, not decoded
    input  logic [cpu_bus_pkg::CPU_ADDR_W-1:0] i_cpu_addr,
    input  logic [cpu_bus_pkg::CPU_DATA_W-1:0] i_cpu_data,

    output logic [cpu_bus_pkg::CPU_DATA_W-1:0] o_cpu_data,
    output logic [cpu_bus_pkg::CPU_DATA_W-1:0] o_cpu_data_oe,
    output logic                               o_cpu_rdy,
    output logic                               o_cpu_reset
);

    import cpu_bus_pkg::*;

    apb_req_t                  req;
    apb_rsp_t [NUM_BANKS-1:0]  bank_rsp;
    apb_rsp_t                  rsp;

    // drive the data pins whenever the cpu reads
    assign o_cpu_data_oe = {CPU_DATA_W{i_cpu_rwb}};

    cpu_bus_bridge u_bridge (
        .i_sysclk     (i_sysclk),
        .i_reset      (i_reset),
        .i_cpu_valid  (i_cpu_valid),
        .i_cpu_rwb    (i_cpu_rwb),
        .i_cpu_addr   (i_cpu_addr),
        .i_cpu_data   (i_cpu_data),
        .i_rsp        (rsp),
        .o_req        (req),
        .o_cpu_data   (o_cpu_data),
        .o_cpu_rdy    (o_cpu_rdy),
        .o_cpu_reset  (o_cpu_reset)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sram_bank u_bank (
            .i_sysclk  (i_sysclk),
            .i_reset   (i_reset),
            .i_sel     (req.psel[b]),
            .i_req     (req),
            .o_rsp     (bank_rsp[b])
        );
    end

    apb_response_mux u_rsp_mux (
        .i_sysclk    (i_sysclk),
        .i_reset     (i_reset),
        .i_req       (req),
        .i_bank_rsp  (bank_rsp),
        .o_rsp       (rsp)
    );

endmodule

// ==== hdl/apb_response_mux.sv ====
`timescale 1ns/100ps

module apb_response_mux (
    input  logic                                           i_sysclk,
    input  logic                                           i_reset,
    input  cpu_bus_pkg::apb_req_t                          i_req,
    input  cpu_bus_pkg::apb_rsp_t [cpu_bus_pkg::NUM_BANKS-1:0] i_bank_rsp,
    output cpu_bus_pkg::apb_rsp_t                          o_rsp
);

    import cpu_bus_pkg::*;

    apb_rsp_t              sel_rsp;
    logic                  sel_ready;
    logic                  rsp_ready;
    logic [BUS_DATA_W-1:0] rsp_data;

    // bank field stays stable across the whole transfer
    assign sel_rsp   = i_bank_rsp[i_req.bank];
    assign sel_ready = sel_rsp.pready & i_req.penable;

    always_ff @(posedge i_sysclk) begin
        if (i_reset) begin
            rsp_ready <= 1'b0;
        end else begin
            rsp_ready <= sel_ready;  // one cycle pulse back to the bridge
        end
    end

    always_ff @(posedge i_sysclk) begin
        if (sel_ready) begin
            rsp_data <= sel_rsp.prdata;
        end
    end

    assign o_rsp.pready = rsp_ready;
    assign o_rsp.prdata = rsp_data;

endmodule

// ==== hdl/sram_bank.sv ====
`timescale 1ns/100ps

module sram_bank (
    input  logic                  i_sysclk,
    input  logic                  i_reset,
    input  logic                  i_sel,
    input  cpu_bus_pkg::apb_req_t i_req,
    output cpu_bus_pkg::apb_rsp_t o_rsp
);

    import cpu_bus_pkg::*;

    logic [BUS_DATA_W-1:0] mem [BANK_WORDS];
    logic                  access;
    logic                  wr_en;

    // no wait states, ready in the first access cycle
    assign access = i_sel & i_req.penable;
    assign wr_en  = access & i_req.pwrite;

    // cleared at reset so reads before any write are known
    always_ff @(posedge i_sysclk) begin
        if (i_reset) begin
            for (int w = 0; w < BANK_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (i_req.pstrb[b]) begin
                    mem[i_req.paddr][b*CPU_DATA_W +: CPU_DATA_W] <=
                        i_req.pwdata[b*CPU_DATA_W +: CPU_DATA_W];
                end
            end
        end
    end

    assign o_rsp.pready = access;
    assign o_rsp.prdata = mem[i_req.paddr];  // async read, same cycle

endmodule

// ==== hdl/cpu_bus_bridge.sv ====
`timescale 1ns/100ps

module cpu_bus_bridge (
    input  logic                               i_sysclk,
    input  logic                               i_reset,

    input  logic                               i_cpu_valid,
    input  logic                               i_cpu_rwb,
    input  logic [cpu_bus_pkg::CPU_ADDR_W-1:0] i_cpu_addr,
    input  logic [cpu_bus_pkg::CPU_DATA_W-1:0] i_cpu_data,

    input  cpu_bus_pkg::apb_rsp_t              i_rsp,
    output cpu_bus_pkg::apb_req_t              o_req,

    output logic [cpu_bus_pkg::CPU_DATA_W-1:0] o_cpu_data,
    output logic                               o_cpu_rdy,
    output logic                               o_cpu_reset
);

    import cpu_bus_pkg::*;

    bridge_state_e state;
    bridge_state_e state_next;

    // latched cpu access
    logic [CPU_ADDR_W-1:0] lat_addr;
    logic                  lat_rwb;
    logic [CPU_DATA_W-1:0] lat_data;

    logic [BANK_IDX_W-1:0] lat_bank;
    logic [WORD_IDX_W-1:0] lat_word;
    logic [LANE_W-1:0]     lat_lane;

    logic                  accept;
    logic                  is_ram;
    logic                  in_transfer;
    logic                  done;
    logic [CPU_DATA_W-1:0] rd_byte;

    // cpu is only stalled while a ram transfer is in flight
    assign o_cpu_rdy = (state == IDLE);
    assign accept    = i_cpu_valid & o_cpu_rdy;

    // the only memory map decode in the design
    assign is_ram = (i_cpu_addr < RAM_LIMIT);

    assign lat_bank = lat_addr[BANK_LSB +: BANK_IDX_W];
    assign lat_word = lat_addr[WORD_LSB +: WORD_IDX_W];
    assign lat_lane = lat_addr[LANE_W-1:0];

    assign in_transfer = (state == SETUP) || (state == ACCESS);
    assign done        = (state == RESPOND) && i_rsp.pready;

    assign rd_byte = i_rsp.prdata[lat_lane*CPU_DATA_W +: CPU_DATA_W];

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept && is_ram) begin
                    state_next = SETUP;
                end
            end
            SETUP:   state_next = ACCESS;
            ACCESS:  state_next = RESPOND;
            RESPOND: begin
                if (i_rsp.pready) begin // response stage latency is not assumed
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge i_sysclk) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // cpu held in reset until one cycle after the system reset drops
    always_ff @(posedge i_sysclk) begin
        if (i_reset) begin
            o_cpu_reset <= 1'b1;
        end else begin
            o_cpu_reset <= 1'b0;
        end
    end

    always_ff @(posedge i_sysclk) begin
        if (accept) begin
            lat_addr <= i_cpu_addr;
            lat_rwb  <= i_cpu_rwb;
            lat_data <= i_cpu_data;
        end
    end

    // read data holds until the next read finishes
    always_ff @(posedge i_sysclk) begin
        if (accept && !is_ram && i_cpu_rwb) begin
            o_cpu_data <= OPEN_BUS_DATA;  // unmapped, answer at once
        end else if (done && lat_rwb) begin
            o_cpu_data <= rd_byte;
        end
    end

    // request fields come from the latched access so they stay stable
    always_comb begin
        o_req.psel    = '0;
        if (in_transfer) begin
            o_req.psel = NUM_BANKS'(1) << lat_bank;
        end
        o_req.penable = (state == ACCESS);
        o_req.pwrite  = ~lat_rwb;
        o_req.paddr   = lat_word;
        o_req.pwdata  = {STRB_W{lat_data}};  // byte on every lane
        o_req.pstrb   = '0;
        if (!lat_rwb) begin
            o_req.pstrb = STRB_W'(1) << lat_lane;
        end
        o_req.bank    = lat_bank;
    end

endmodule

// ==== common/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

    // cpu side
    localparam int CPU_ADDR_W = 16;
    localparam int CPU_DATA_W = 8;

    // system bus side
    localparam int BUS_DATA_W = 32;
    localparam int STRB_W     = BUS_DATA_W / CPU_DATA_W; // one strobe per cpu byte

    // ram layout, addr[1:0] lane, addr[7:2] word, addr[9:8] bank
    localparam int NUM_BANKS  = 4;
    localparam int BANK_WORDS = 64;
    localparam int LANE_W     = 2;
    localparam int WORD_IDX_W = 6;
    localparam int BANK_IDX_W = 2;

    localparam int WORD_LSB = LANE_W;
    localparam int BANK_LSB = LANE_W + WORD_IDX_W;

    localparam logic [CPU_ADDR_W-1:0] RAM_LIMIT     = 16'h0400; // first address above ram
    localparam logic [CPU_DATA_W-1:0] OPEN_BUS_DATA = 8'hff;

    // request broadcast from the bridge to all banks
    typedef struct packed {
        logic [NUM_BANKS-1:0]  psel;     // one bit per bank
        logic                  penable;
        logic                  pwrite;
        logic [WORD_IDX_W-1:0] paddr;    // word index inside the bank
        logic [BUS_DATA_W-1:0] pwdata;
        logic [STRB_W-1:0]     pstrb;
        logic [BANK_IDX_W-1:0] bank;     // steers the response mux
    } apb_req_t;

    // response of one slave
    typedef struct packed {
        logic                  pready;
        logic [BUS_DATA_W-1:0] prdata;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        RESPOND  // wait for the registered pready
    } bridge_state_e;

endpackage
